/* logic/i2s_pkg.sv */
// Shared widths, register map and configuration types
// for the I2S receive port

package i2s_pkg;

    localparam int DATA_W     = 32;
    localparam int ADDR_W     = 5;
    localparam int DIV_W      = 16;
    localparam int BITS_W     = 5;
    localparam int FIFO_DEPTH = 4;
    localparam int PTR_W      = $clog2(FIFO_DEPTH);
    localparam int CNT_W      = PTR_W + 1;

    // Bit positions inside the register words
    localparam int CLK_EN_BIT    = 16;
    localparam int RX_LSB_BIT    = 8;
    localparam int RX_EN_BIT     = 9;
    localparam int STAT_OVF_BIT  = 0;

    //////////////////////////////////////////////////////////////////////
    // Register word addresses
    //////////////////////////////////////////////////////////////////////
    typedef enum logic [ADDR_W-1:0] {
        REG_CLK    = 5'd0,
        REG_RX     = 5'd1,
        REG_STATUS = 5'd2
    } reg_addr_e;

    // Port configuration, 24 bits
    typedef struct packed {
        logic [DIV_W-1:0]  div;
        logic              clk_en;
        logic [BITS_W-1:0] bits_word;
        logic              lsb_first;
        logic              rx_en;
    } rx_cfg_t;

    // One finished lane word, sample right-aligned
    typedef struct packed {
        logic [DATA_W-1:0] data;
        logic              left;
    } lane_word_t;

endpackage

/* logic/i2s_reg_if.sv */
// Configuration registers, read-back path and sticky overflow status

`timescale 1ns/1ps

module i2s_reg_if (
    input  logic                       sys_clk_i,
    input  logic                       rst_n_i,
    input  logic [i2s_pkg::DATA_W-1:0] cfg_data_i,
    input  logic [i2s_pkg::ADDR_W-1:0] cfg_addr_i,
    input  logic                       cfg_valid_i,
    input  logic                       cfg_rwn_i,
    output logic                       cfg_ready_o,
    output logic [i2s_pkg::DATA_W-1:0] cfg_data_o,
    input  logic                       overflow_i,
    output i2s_pkg::rx_cfg_t           cfg_o
);
    import i2s_pkg::*;

    rx_cfg_t           cfg_q;
    logic              ovf_q;
    logic              req;
    reg_addr_e         addr;
    logic [DATA_W-1:0] rdata;

    // A request is taken once, in the cycle before ready
    assign req  = cfg_valid_i & ~cfg_ready_o;
    assign addr = reg_addr_e'(cfg_addr_i);

    always_comb begin
        rdata = '0;
        case (addr)
            REG_CLK: begin
                rdata[DIV_W-1:0]  = cfg_q.div;
                rdata[CLK_EN_BIT] = cfg_q.clk_en;
            end
            REG_RX: begin
                rdata[BITS_W-1:0] = cfg_q.bits_word;
                rdata[RX_LSB_BIT] = cfg_q.lsb_first;
                rdata[RX_EN_BIT]  = cfg_q.rx_en;
            end
            REG_STATUS: rdata[STAT_OVF_BIT] = ovf_q;
            default: rdata = '0;
        endcase
    end

    always_ff @(posedge sys_clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            cfg_q       <= '0;
            ovf_q       <= 1'b0;
            cfg_ready_o <= 1'b0;
            cfg_data_o  <= '0;
        end else begin
            cfg_ready_o <= req;
            cfg_data_o  <= (req && cfg_rwn_i) ? rdata : '0;
            if (req && !cfg_rwn_i) begin
                case (addr)
                    REG_CLK: begin
                        cfg_q.div    <= cfg_data_i[DIV_W-1:0];
                        cfg_q.clk_en <= cfg_data_i[CLK_EN_BIT];
                    end
                    REG_RX: begin
                        cfg_q.bits_word <= cfg_data_i[BITS_W-1:0];
                        cfg_q.lsb_first <= cfg_data_i[RX_LSB_BIT];
                        cfg_q.rx_en     <= cfg_data_i[RX_EN_BIT];
                    end
                    default: ;
                endcase
            end
            // New overflow wins over a clear in the same cycle
            if (overflow_i) begin
                ovf_q <= 1'b1;
            end else if (req && !cfg_rwn_i && addr == REG_STATUS
                         && cfg_data_i[STAT_OVF_BIT]) begin
                ovf_q <= 1'b0;
            end
        end
    end

    assign cfg_o = cfg_q;

endmodule

/* logic/i2s_clkws_gen.sv */
// Serial clock divider with rise strobe and word select generation

`timescale 1ns/1ps

module i2s_clkws_gen (
    input  logic             sys_clk_i,
    input  logic             rst_n_i,
    input  i2s_pkg::rx_cfg_t cfg_i,
    output logic             sck_o,
    output logic             sck_oe_o,
    output logic             ws_o,
    output logic             ws_oe_o,
    output logic             rise_o
);
    import i2s_pkg::*;

    logic [DIV_W-1:0]  div_cnt_q;
    logic [BITS_W-1:0] bit_cnt_q;
    logic              half_done;

    // Half period is div+1 sys cycles
    assign half_done = (div_cnt_q >= cfg_i.div);

    always_ff @(posedge sys_clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            div_cnt_q <= '0;
            bit_cnt_q <= '0;
            sck_o     <= 1'b0;
            ws_o      <= 1'b0;
            rise_o    <= 1'b0;
        end else if (!cfg_i.clk_en) begin
            div_cnt_q <= '0;
            bit_cnt_q <= '0;
            sck_o     <= 1'b0;
            ws_o      <= 1'b0;
            rise_o    <= 1'b0;
        end else begin
            rise_o <= 1'b0;
            if (half_done) begin
                div_cnt_q <= '0;
                sck_o     <= ~sck_o;
                rise_o    <= ~sck_o;
                // Falling edge: advance the bit slot, ws flips after the last one
                if (sck_o) begin
                    if (bit_cnt_q >= cfg_i.bits_word) begin
                        bit_cnt_q <= '0;
                        ws_o      <= ~ws_o;
                    end else begin
                        bit_cnt_q <= bit_cnt_q + 1'b1;
                    end
                end
            end else begin
                div_cnt_q <= div_cnt_q + 1'b1;
            end
        end
    end

    assign sck_oe_o = cfg_i.clk_en;
    assign ws_oe_o  = cfg_i.clk_en;

endmodule

/* logic/i2s_rx_lane.sv */
// Deserializer for one I2S data lane, one-bit delay,
// MSB-first or LSB-first word assembly

`timescale 1ns/1ps

module i2s_rx_lane (
    input  logic                sys_clk_i,
    input  logic                rst_n_i,
    input  i2s_pkg::rx_cfg_t    cfg_i,
    input  logic                rise_i,
    input  logic                ws_i,
    input  logic                sd_i,
    output i2s_pkg::lane_word_t word_o,
    output logic                word_valid_o
);
    import i2s_pkg::*;

    logic              ws_q;
    logic              armed_q;
    logic              ws_edge;
    logic [BITS_W-1:0] bit_cnt_q;
    logic [DATA_W-1:0] shift_q;
    logic [DATA_W-1:0] shift_d;

    assign ws_edge = ws_i ^ ws_q;

    always_comb begin
        shift_d = shift_q;
        if (cfg_i.lsb_first) begin
            shift_d[bit_cnt_q] = sd_i;
        end else begin
            shift_d = {shift_q[DATA_W-2:0], sd_i};
        end
    end

    // The rise on a ws edge carries the last bit of the previous word
    assign word_valid_o = rise_i & ws_edge & armed_q & (bit_cnt_q == cfg_i.bits_word);
    assign word_o       = {shift_d, ~ws_q};

    always_ff @(posedge sys_clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            ws_q      <= 1'b0;
            bit_cnt_q <= '0;
        end else if (rise_i) begin
            ws_q      <= ws_i;
            bit_cnt_q <= ws_edge ? '0 : bit_cnt_q + 1'b1;
        end
    end

    always_ff @(posedge sys_clk_i) begin
        if (rise_i) begin
            shift_q <= ws_edge ? '0 : shift_d;
        end
    end

    // Words count only from the first ws edge seen with rx_en set
    always_ff @(posedge sys_clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            armed_q <= 1'b0;
        end else if (!cfg_i.rx_en) begin
            armed_q <= 1'b0;
        end else if (rise_i && ws_edge) begin
            armed_q <= 1'b1;
        end
    end

endmodule

/* logic/i2s_rx_packer.sv */
// Pair packer for the two lanes into a four-entry output queue
// with overflow detection

`timescale 1ns/1ps

module i2s_rx_packer (
    input  logic                       sys_clk_i,
    input  logic                       rst_n_i,
    input  i2s_pkg::lane_word_t        word0_i,
    input  i2s_pkg::lane_word_t        word1_i,
    input  logic                       word_valid_i,
    output logic [i2s_pkg::DATA_W-1:0] data_o,
    output logic                       valid_o,
    input  logic                       ready_i,
    output logic                       overflow_o
);
    import i2s_pkg::*;

    logic [DATA_W-1:0] mem_q [FIFO_DEPTH];
    logic [PTR_W-1:0]  wr_ptr_q;
    logic [PTR_W-1:0]  rd_ptr_q;
    logic [CNT_W-1:0]  count_q;
    logic              pair_ok;
    logic              room;
    logic              push;
    logic              pop;

    // Lanes share ws, so a true pair carries the same channel tag
    assign pair_ok = word_valid_i & (word0_i.left == word1_i.left);
    // Free space is judged before this cycle's pop
    assign room    = (count_q <= CNT_W'(FIFO_DEPTH - 2));
    assign push    = pair_ok & room;
    assign pop     = valid_o & ready_i;

    assign valid_o = (count_q != '0);
    assign data_o  = mem_q[rd_ptr_q];

    always_ff @(posedge sys_clk_i) begin
        if (push) begin
            mem_q[wr_ptr_q]        <= word0_i.data;
            mem_q[wr_ptr_q + 1'b1] <= word1_i.data;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Pointers, fill level and loss pulse
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge sys_clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wr_ptr_q   <= '0;
            rd_ptr_q   <= '0;
            count_q    <= '0;
            overflow_o <= 1'b0;
        end else begin
            overflow_o <= word_valid_i & ~push;
            if (push) begin
                wr_ptr_q <= wr_ptr_q + 2'd2;
            end
            if (pop) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            case ({push, pop})
                2'b10:   count_q <= count_q + 2'd2;
                2'b11:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

endmodule

/* logic/i2s_rx_top.sv */
// Receive-only I2S port: register file, clock and ws generator,
// two data lanes and the output packer

`timescale 1ns/1ps

module i2s_rx_top (
    input  logic                       sys_clk_i,
    input  logic                       rst_n_i,
    input  logic [i2s_pkg::DATA_W-1:0] cfg_data_i,
    input  logic [i2s_pkg::ADDR_W-1:0] cfg_addr_i,
    input  logic                       cfg_valid_i,
    input  logic                       cfg_rwn_i,
    output logic                       cfg_ready_o,
    output logic [i2s_pkg::DATA_W-1:0] cfg_data_o,
    input  logic                       pad_slave_sd0_i,
    input  logic                       pad_slave_sd1_i,
    output logic                       pad_slave_sck_o,
    output logic                       pad_slave_sck_oe_o,
    output logic                       pad_slave_ws_o,
    output logic                       pad_slave_ws_oe_o,
    output logic [i2s_pkg::DATA_W-1:0] data_rx_o,
    output logic                       data_rx_valid_o,
    input  logic                       data_rx_ready_i
);
    import i2s_pkg::*;

    rx_cfg_t    s_cfg;
    logic       s_rise;
    logic       s_overflow;
    lane_word_t s_word0;
    lane_word_t s_word1;
    logic       s_word0_valid;
    logic       s_word1_valid;

    i2s_reg_if u_reg_if (
        .sys_clk_i   ( sys_clk_i   ),
        .rst_n_i     ( rst_n_i     ),
        .cfg_data_i  ( cfg_data_i  ),
        .cfg_addr_i  ( cfg_addr_i  ),
        .cfg_valid_i ( cfg_valid_i ),
        .cfg_rwn_i   ( cfg_rwn_i   ),
        .cfg_ready_o ( cfg_ready_o ),
        .cfg_data_o  ( cfg_data_o  ),
        .overflow_i  ( s_overflow  ),
        .cfg_o       ( s_cfg       )
    );

    i2s_clkws_gen u_clkws_gen (
        .sys_clk_i ( sys_clk_i          ),
        .rst_n_i   ( rst_n_i            ),
        .cfg_i     ( s_cfg              ),
        .sck_o     ( pad_slave_sck_o    ),
        .sck_oe_o  ( pad_slave_sck_oe_o ),
        .ws_o      ( pad_slave_ws_o     ),
        .ws_oe_o   ( pad_slave_ws_oe_o  ),
        .rise_o    ( s_rise             )
    );

    i2s_rx_lane u_lane0 (
        .sys_clk_i    ( sys_clk_i       ),
        .rst_n_i      ( rst_n_i         ),
        .cfg_i        ( s_cfg           ),
        .rise_i       ( s_rise          ),
        .ws_i         ( pad_slave_ws_o  ),
        .sd_i         ( pad_slave_sd0_i ),
        .word_o       ( s_word0         ),
        .word_valid_o ( s_word0_valid   )
    );

    i2s_rx_lane u_lane1 (
        .sys_clk_i    ( sys_clk_i       ),
        .rst_n_i      ( rst_n_i         ),
        .cfg_i        ( s_cfg           ),
        .rise_i       ( s_rise          ),
        .ws_i         ( pad_slave_ws_o  ),
        .sd_i         ( pad_slave_sd1_i ),
        .word_o       ( s_word1         ),
        .word_valid_o ( s_word1_valid   )
    );

    // Both lanes finish on the same rise
    i2s_rx_packer u_packer (
        .sys_clk_i    ( sys_clk_i                     ),
        .rst_n_i      ( rst_n_i                       ),
        .word0_i      ( s_word0                       ),
        .word1_i      ( s_word1                       ),
        .word_valid_i ( s_word0_valid & s_word1_valid ),
        .data_o       ( data_rx_o                     ),
        .valid_o      ( data_rx_valid_o               ),
        .ready_i      ( data_rx_ready_i               ),
        .overflow_o   ( s_overflow                    )
    );

endmodule

/* verification/tb_i2s_rx.sv */
// Testbench for the I2S receive port with a golden-file audio source,
// output monitor, register and back-pressure checks

`timescale 1ns/1ps

module tb_i2s_rx;
    import i2s_pkg::*;

    localparam int NUM_TESTS = 3;

    logic        sys_clk_i = 1'b0;
    logic        rst_n_i;
    logic [31:0] cfg_data_i;
    logic [4:0]  cfg_addr_i;
    logic        cfg_valid_i;
    logic        cfg_rwn_i;
    logic        cfg_ready_o;
    logic [31:0] cfg_data_o;
    logic        pad_slave_sd0_i;
    logic        pad_slave_sd1_i;
    logic        pad_slave_sck_o;
    logic        pad_slave_sck_oe_o;
    logic        pad_slave_ws_o;
    logic        pad_slave_ws_oe_o;
    logic [31:0] data_rx_o;
    logic        data_rx_valid_o;
    logic        data_rx_ready_i;

    logic [31:0] gold [64];
    int          t_div  [NUM_TESTS];
    int          t_bits [NUM_TESTS];
    int          t_lsb  [NUM_TESTS];
    int          t_np   [NUM_TESTS];
    int          t_base [NUM_TESTS];
    logic [31:0] got [$];
    int          cycles = 0;
    int          limit = 1000000;
    int          src_test = 0;
    int          src_slot = 0;
    int          src_bit = 0;
    logic        sck_prev = 1'b0;
    logic        ws_prev = 1'b0;

    i2s_rx_top u_i2s_rx_top (.*);

    always #4 sys_clk_i = ~sys_clk_i;

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("test failed");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            fail_run($sformatf("** Error at time %0t: %s = 0x%08h, expected 0x%08h",
                               $time, name, actual, expected));
        end
    endtask

    always @(posedge sys_clk_i) begin
        cycles = cycles + 1;
        if (cycles > limit) begin
            fail_run($sformatf("Timeout: the run did not finish within %0d cycles", limit));
        end
    end

    // Low bits_word+1 bits of a golden word
    function automatic logic [31:0] expected_word(input int t, input int pair, input int lane);
        logic [63:0] mask;
        mask = (64'd1 << (t_bits[t] + 1)) - 64'd1;
        return gold[t_base[t] + 2 * pair + lane] & mask[31:0];
    endfunction

    // Slot 0 is the partial word after enable and slots past the record send zero
    function automatic logic slot_bit(input int t, input int slot, input int lane, input int idx);
        logic [31:0] w;
        w = '0;
        if (slot > 0 && slot <= t_np[t]) begin
            w = gold[t_base[t] + 2 * (slot - 1) + lane];
        end
        return (t_lsb[t] != 0) ? w[idx] : w[t_bits[t] - idx];
    endfunction

    //////////////////////////////////////////////////////////////////////
    // Audio source and output monitor
    //////////////////////////////////////////////////////////////////////
    // A new bit goes out on each falling sck and the last bit of a word with the ws change
    always @(posedge sys_clk_i) begin
        #1;
        if (sck_prev && !pad_slave_sck_o) begin
            if (pad_slave_ws_o != ws_prev) begin
                pad_slave_sd0_i = slot_bit(src_test, src_slot, 0, t_bits[src_test]);
                pad_slave_sd1_i = slot_bit(src_test, src_slot, 1, t_bits[src_test]);
                src_slot = src_slot + 1;
                src_bit  = 0;
            end else begin
                pad_slave_sd0_i = slot_bit(src_test, src_slot, 0, src_bit);
                pad_slave_sd1_i = slot_bit(src_test, src_slot, 1, src_bit);
                src_bit = src_bit + 1;
            end
        end
        sck_prev = pad_slave_sck_o;
        ws_prev  = pad_slave_ws_o;
    end

    always @(negedge sys_clk_i) begin
        if (data_rx_valid_o && data_rx_ready_i) begin
            got.push_back(data_rx_o);
        end
    end

    task automatic reg_access(input logic rwn, input logic [4:0] addr,
                              input logic [31:0] wdata, output logic [31:0] rdata);
        @(posedge sys_clk_i);
        #1;
        cfg_valid_i = 1'b1;
        cfg_rwn_i   = rwn;
        cfg_addr_i  = addr;
        cfg_data_i  = wdata;
        @(posedge sys_clk_i);
        #1;
        while (!cfg_ready_o) begin
            @(posedge sys_clk_i);
            #1;
        end
        rdata       = cfg_data_o;
        cfg_valid_i = 1'b0;
    endtask

    task automatic reg_write(input logic [4:0] addr, input logic [31:0] wdata);
        logic [31:0] unused;
        reg_access(1'b0, addr, wdata, unused);
    endtask

    task automatic reg_read(input logic [4:0] addr, output logic [31:0] rdata);
        reg_access(1'b1, addr, 32'd0, rdata);
    endtask

    task automatic load_golden();
        int p;
        int t;
        p = 0;
        limit = 2000;
        $readmemh("verification/i2s_rx_golden.txt", gold);
        for (t = 0; t < NUM_TESTS; t++) begin
            if ($isunknown(gold[p + 3])) begin
                fail_run("Golden file is missing or has too few records");
            end
            t_div[t]  = int'(gold[p]);
            t_bits[t] = int'(gold[p + 1]);
            t_lsb[t]  = int'(gold[p + 2]);
            t_np[t]   = int'(gold[p + 3]);
            t_base[t] = p + 4;
            p = p + 4 + 2 * t_np[t];
            limit = limit + 2 * t_np[t] * 2 * (t_div[t] + 1) * (t_bits[t] + 1);
        end
        if ($isunknown(gold[p - 1])) begin
            fail_run("Golden file ends inside a record");
        end
    endtask

    // Pad drivers and handshakes are quiet out of reset
    task automatic check_reset_outputs();
        check_value("cfg_ready_o", cfg_ready_o, 32'd0);
        check_value("data_rx_valid_o", data_rx_valid_o, 32'd0);
        check_value("pad_slave_sck_o", pad_slave_sck_o, 32'd0);
        check_value("pad_slave_ws_o", pad_slave_ws_o, 32'd0);
        check_value("pad_slave_sck_oe_o", pad_slave_sck_oe_o, 32'd0);
        check_value("pad_slave_ws_oe_o", pad_slave_ws_oe_o, 32'd0);
    endtask

    task automatic check_pad_enables(input logic en);
        check_value("pad_slave_sck_oe_o", pad_slave_sck_oe_o, {31'd0, en});
        check_value("pad_slave_ws_oe_o", pad_slave_ws_oe_o, {31'd0, en});
    endtask

    task automatic check_registers();
        logic [31:0] rd;
        reg_read(REG_STATUS, rd);
        check_value("REG_STATUS", rd, 32'd0);
        reg_write(REG_CLK, 32'hfffe_1234);
        check_pad_enables(1'b0);
        reg_read(REG_CLK, rd);
        check_value("REG_CLK", rd, 32'h0000_1234);
        reg_write(REG_RX, 32'hffff_fdf3);
        reg_read(REG_RX, rd);
        check_value("REG_RX", rd, 32'h0000_0113);
        reg_read(5'd3, rd);
        check_value("unmapped register", rd, 32'd0);
    endtask

    task automatic configure(input int t);
        logic [31:0] rd;
        logic [31:0] rx_word;
        logic [31:0] clk_word;
        rx_word  = {22'd0, 1'b1, t_lsb[t][0], 3'd0, t_bits[t][4:0]};
        clk_word = {15'd0, 1'b1, t_div[t][15:0]};
        src_test = t;
        src_slot = 0;
        src_bit  = 0;
        got.delete();
        reg_write(REG_RX, rx_word);
        reg_read(REG_RX, rd);
        check_value("REG_RX", rd, rx_word);
        reg_write(REG_CLK, clk_word);
        check_pad_enables(clk_word[16]);
        reg_read(REG_CLK, rd);
        check_value("REG_CLK", rd, clk_word);
    endtask

    task automatic wait_ws_edge(output int at_cycle);
        logic ws_old;
        ws_old = pad_slave_ws_o;
        while (pad_slave_ws_o == ws_old) begin
            @(posedge sys_clk_i);
            #1;
        end
        at_cycle = cycles;
    endtask

    // Stop on a rise with ws low so that the lanes also hold ws low
    task automatic stop_port();
        logic sck_old;
        @(posedge sys_clk_i);
        #1;
        sck_old = 1'b1;
        while (!(pad_slave_sck_o && !sck_old && !pad_slave_ws_o)) begin
            sck_old = pad_slave_sck_o;
            @(posedge sys_clk_i);
            #1;
        end
        reg_write(REG_CLK, 32'd0);
        check_pad_enables(1'b0);
        reg_write(REG_RX, 32'd0);
        while (data_rx_valid_o) begin
            @(posedge sys_clk_i);
            #1;
        end
    endtask

    task automatic run_stream_test(input int t);
        int first;
        int second;
        int i;
        configure(t);
        wait_ws_edge(first);
        wait_ws_edge(second);
        check_value("ws edge spacing", 32'(second - first),
                    32'(2 * (t_div[t] + 1) * (t_bits[t] + 1)));
        while (got.size() < 2 * t_np[t]) @(posedge sys_clk_i);
        for (i = 0; i < 2 * t_np[t]; i++) begin
            check_value("data_rx_o", got[i], expected_word(t, i / 2, i % 2));
        end
        stop_port();
    endtask

    task automatic run_backpressure_test(input int t);
        logic [31:0] rd;
        logic        found;
        int          k;
        int          j;
        int          last;
        data_rx_ready_i = 1'b0;
        configure(t);
        // Pairs 0 and 1 fill the queue and slots 3 to 5 are lost
        while (src_slot < 6) @(posedge sys_clk_i);
        repeat (4) @(posedge sys_clk_i);
        #1;
        data_rx_ready_i = 1'b1;
        while (got.size() < 4) @(posedge sys_clk_i);
        for (k = 0; k < 4; k++) begin
            check_value("data_rx_o", got[k], expected_word(t, k / 2, k % 2));
        end
        reg_read(REG_STATUS, rd);
        check_value("REG_STATUS", rd, 32'd1);
        reg_write(REG_STATUS, 32'd1);
        reg_read(REG_STATUS, rd);
        check_value("REG_STATUS", rd, 32'd0);
        while (src_slot <= t_np[t]) @(posedge sys_clk_i);
        repeat (4) @(posedge sys_clk_i);
        #1;
        while (data_rx_valid_o) begin
            @(posedge sys_clk_i);
            #1;
        end
        if (got.size() % 2 != 0 || got.size() < 6) begin
            fail_run("Back-pressure run gave an odd or too small number of words");
        end
        last = -1;
        for (k = 4; k < got.size(); k += 2) begin
            found = 1'b0;
            for (j = last + 1; j < t_np[t] && !found; j++) begin
                if (got[k] == expected_word(t, j, 0) && got[k + 1] == expected_word(t, j, 1)) begin
                    found = 1'b1;
                    last  = j;
                end
            end
            if (!found) begin
                fail_run($sformatf("Output pair %0d is not a later golden pair", k / 2));
            end
        end
    endtask

    initial begin
        rst_n_i         = 1'b0;
        cfg_data_i      = '0;
        cfg_addr_i      = '0;
        cfg_valid_i     = 1'b0;
        cfg_rwn_i       = 1'b0;
        pad_slave_sd0_i = 1'b0;
        pad_slave_sd1_i = 1'b0;
        data_rx_ready_i = 1'b1;
        load_golden();
        repeat (8) @(posedge sys_clk_i);
        #1;
        rst_n_i = 1'b1;
        check_reset_outputs();
        check_registers();
        run_stream_test(0);
        run_stream_test(1);
        run_backpressure_test(2);
        $display("test passed");
        $finish;
    end

endmodule

/* sim.f */
logic/i2s_pkg.sv
logic/i2s_reg_if.sv
logic/i2s_clkws_gen.sv
logic/i2s_rx_lane.sv
logic/i2s_rx_packer.sv
logic/i2s_rx_top.sv
verification/tb_i2s_rx.sv

/* run.sh */
#!/bin/sh
# Build and run the I2S receive testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module tb_i2s_rx -f sim.f

# The simulator exits non-zero on a failed check, the search below decides
out=$(./obj_dir/Vtb_i2s_rx 2>&1) || true
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -qx "test passed"

/* verification/i2s_rx_golden.txt */
// Config record: div bits_word lsb_first pair_count
// Then one slot per line in transmission order: lane0_word lane1_word
0001 0000000f 0 5
a5c3f00d 12345678
dead8001 0000ffff
7fff0002 cafe8000
00010f0f 5a5a1234
ffff7e81 80004321
0002 00000017 1 5
00abcdef 00123456
ff800001 00fedcba
12c0ffee 00000001
00800000 3a7fffff
00555aaa 99aaaaaa
0000 00000007 0 8
000000a1 000000b2
000001c3 000000d4
000000e5 0000fff6
00000017 00000028
00000039 0000004a
0000005b 0000006c
0000007d 0000008e
0000009f 000000f0
